// File: Bender.yml
package:
  name: six_stage_pipeline

sources:
  - verilog/isa_pkg.sv
  - verilog/pipe_pkg.sv
  - verilog/forward_if.sv
  - verilog/instruction_decode.sv
  - verilog/register_file.sv
  - verilog/hazard_unit.sv
  - verilog/alu.sv
  - verilog/branch_unit.sv
  - verilog/six_stage_pipeline.sv
  - target: any(simulation, test)
    files:
      - dv/pipeline_assertions.sv
      - dv/pipeline_checker.sv
      - dv/pipeline_tb.sv

// File: compile.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/forward_if.sv
verilog/instruction_decode.sv
verilog/register_file.sv
verilog/hazard_unit.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/six_stage_pipeline.sv
dv/pipeline_assertions.sv
dv/pipeline_checker.sv
dv/pipeline_tb.sv

// File: dv/pipeline_assertions.sv
`timescale 1ns/1ps
// concurrent assertions bound to the pipeline top
// reset quiet outputs, no store under flush, no x0 write
module pipeline_assertions (
	input logic clk,
	input logic reset,
	input logic retire_valid,
	input logic retire_write,
	input logic [4:0] retire_rd_index,
	input logic dmem_write,
	input logic mispredict
);
	int failures = 0;	// read by the testbench

	// second reset cycle onward, state is cleared by then
	quiet_in_reset: assert property (@(posedge clk)
		!reset && $past(!reset) |-> !retire_valid && !dmem_write)
		else begin
			$error("retire or store while reset is low");
			failures++;
		end

	no_store_on_flush: assert property (@(posedge clk) disable iff (!reset)
		mispredict |-> !dmem_write)
		else begin
			$error("store during mispredict flush");
			failures++;
		end

	no_x0_write: assert property (@(posedge clk) disable iff (!reset)
		retire_write |-> retire_rd_index != 5'd0)
		else begin
			$error("retire_write with rd x0");
			failures++;
		end
endmodule

// File: dv/pipeline_checker.sv
`timescale 1ns/1ps
// architectural model of the rv32i subset
// steps one instruction per retirement and compares trace and stores
module pipeline_checker (
	input logic clk,
	input logic reset,
	input logic retire_valid,
	input logic [31:0] retire_pc,
	input logic [4:0] retire_rd_index,
	input logic [31:0] retire_rd,
	input logic retire_write,
	input logic [9:0] dmem_addr,
	input logic [31:0] dmem_wdata,
	input logic dmem_write
);
	logic [31:0] regs [0:31];
	logic [31:0] mem [0:255];
	logic [31:0] pc;
	logic [41:0] stores [$];	// observed {addr, data}, oldest first
	int errors = 0;
	int retired = 0;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic step_model();
		isa_pkg::instr_t w;
		logic [31:0] imm_i, imm_s, imm_b, imm_j, a, b, val, next, addr;
		logic wr;
		logic [41:0] seen;
		w = pipeline_tb.imem[pc[9:2]];
		imm_i = {{20{w.i.imm[11]}}, w.i.imm};
		imm_s = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
		imm_b = {{20{w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
		imm_j = {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
		a = regs[w.r.rs1];
		b = regs[w.r.rs2];
		val = '0;
		wr = 1'b0;
		next = pc + 4;
		case (w.r.opcode)
			isa_pkg::OP_LUI: begin
				val = {w.u.imm, 12'b0};
				wr = 1'b1;
			end
			isa_pkg::OP_AUIPC: begin
				val = pc + {w.u.imm, 12'b0};
				wr = 1'b1;
			end
			isa_pkg::OP_JAL: begin
				val = pc + 4;
				wr = 1'b1;
				next = pc + imm_j;
			end
			isa_pkg::OP_JALR: begin
				val = pc + 4;
				wr = 1'b1;
				next = (a + imm_i) & ~32'd1;
			end
			isa_pkg::OP_BRANCH:
				if ((w.b.funct3 == isa_pkg::F3_BNE) != (a == b))
					next = pc + imm_b;
			isa_pkg::OP_LOAD: begin
				addr = a + imm_i;
				val = mem[addr[9:2]];
				wr = 1'b1;
			end
			isa_pkg::OP_STORE: begin
				addr = a + imm_s;
				mem[addr[9:2]] = b;
				if (stores.size() == 0) begin
					$display("store at pc %h never reached the data memory", pc);
					errors++;
				end else begin
					seen = stores.pop_front();
					compare("dmem_addr", {22'b0, seen[41:32]}, {22'b0, addr[9:0]});
					compare("dmem_wdata", seen[31:0], b);
				end
			end
			isa_pkg::OP_IMM, isa_pkg::OP_REG: begin
				if (w.r.opcode == isa_pkg::OP_IMM)
					b = imm_i;
				wr = 1'b1;
				case (w.r.funct3)
					isa_pkg::F3_SLT: val = {31'b0, $signed(a) < $signed(b)};
					isa_pkg::F3_XOR: val = a ^ b;
					isa_pkg::F3_OR: val = a | b;
					isa_pkg::F3_AND: val = a & b;
					default: val = (w.r.opcode == isa_pkg::OP_REG &&
						w.r.funct7 == isa_pkg::F7_SUB) ? a - b : a + b;
				endcase
			end
			default: ;
		endcase
		wr = wr && w.r.rd != 5'd0;
		compare("retire_pc", retire_pc, pc);
		compare("retire_write", {31'b0, retire_write}, {31'b0, wr});
		if (wr) begin
			compare("retire_rd_index", {27'b0, retire_rd_index}, {27'b0, w.r.rd});
			compare("retire_rd", retire_rd, val);
			regs[w.r.rd] = val;
		end
		if (stores.size() != 0) begin	// wrong-path store slipped through
			$display("store to %h was made by no retired instruction", stores[0][41:32]);
			errors++;
			stores.delete();
		end
		pc = next;
		retired++;
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			pc = '0;
			stores.delete();
			for (int r = 0; r < 32; r++)
				regs[r] = '0;
			for (int m = 0; m < 256; m++)
				mem[m] = pipeline_tb.dmem[m];
		end else begin
			if (retire_valid)
				step_model();
			if (dmem_write)
				stores.push_back({dmem_addr, dmem_wdata});	// after retire, matched next cycle
		end
	end
endmodule

// File: dv/pipeline_tb.sv
`timescale 1ns/1ps
// testbench for the six-stage core
// clock, reset, both memories, random program generator, test loop
module pipeline_tb;
	localparam int TESTS = 6;
	localparam int LEN = 40;
	localparam logic [31:0] HALT_PC = (LEN - 1) * 4;
	localparam int LUI = 0, AUIPC = 1, JAL = 2, PAIR = 3, BEQ = 4, BNE = 5;
	localparam int LW = 6, SW = 7, BASE = 12, JALR = 13, HALT = 14;

	logic clk = 1'b0;
	logic reset;
	logic [9:0] imem_addr, dmem_addr;
	logic [31:0] imem_data, dmem_wdata, dmem_rdata, retire_pc, retire_rd;
	logic dmem_write, retire_valid, retire_write;
	logic [4:0] retire_rd_index;
	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	int kind [0:LEN-1];
	logic [4:0] base [0:LEN-1];
	int failed = 0;

	always #20 clk = ~clk;

	assign imem_data = imem[imem_addr[9:2]];	// asynchronous reads
	assign dmem_rdata = dmem[dmem_addr[9:2]];
	always @(posedge clk)
		if (dmem_write)
			dmem[dmem_addr[9:2]] <= dmem_wdata;

	six_stage_pipeline six_stage_pipeline_inst (.*);

	pipeline_checker checker_inst (.*);

	bind six_stage_pipeline pipeline_assertions assertions_inst (
		.clk(clk), .reset(reset), .retire_valid(retire_valid),
		.retire_write(retire_write), .retire_rd_index(retire_rd_index),
		.dmem_write(dmem_write), .mispredict(mispredict));

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		isa_pkg::instr_t w;
		w.i.imm = imm;
		w.i.rs1 = rs1;
		w.i.funct3 = f3;
		w.i.rd = rd;
		w.i.opcode = op;
		return w.word;
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		isa_pkg::instr_t w;
		w.b.imm_12 = imm[12];
		w.b.imm_11 = imm[11];
		w.b.imm_10_5 = imm[10:5];
		w.b.imm_4_1 = imm[4:1];
		w.b.rs2 = rs2;
		w.b.rs1 = rs1;
		w.b.funct3 = f3;
		w.b.opcode = isa_pkg::OP_BRANCH;
		return w.word;
	endfunction

	function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
		isa_pkg::instr_t w;
		w.j.imm_20 = imm[20];
		w.j.imm_19_12 = imm[19:12];
		w.j.imm_11 = imm[11];
		w.j.imm_10_1 = imm[10:1];
		w.j.rd = rd;
		w.j.opcode = isa_pkg::OP_JAL;
		return w.word;
	endfunction

	// forward target, never onto a jalr whose base was skipped
	function automatic int target_of(input int from);
		int t;
		t = from + 1 + $urandom % 4;
		if (t > LEN - 1)
			t = LEN - 1;
		if (kind[t] == JALR)
			t++;
		return t;
	endfunction

	task automatic build_program();
		isa_pkg::instr_t w;
		logic [2:0] f3s [0:4];
		int unsigned sel;
		int t;
		f3s = '{isa_pkg::F3_ADD, isa_pkg::F3_SLT, isa_pkg::F3_XOR,
			isa_pkg::F3_OR, isa_pkg::F3_AND};
		for (int a = 0; a < 256; a++) begin
			imem[a] = {a[7:0], ~a[7:0], a[7:0], 8'hff};	// opcode 7f, a no-op
			dmem[a] = {a[7:0] ^ 8'h5a, ~a[7:0], a[7:0], 8'h3c};
		end
		for (int i = 0; i < LEN - 1; i++) begin
			kind[i] = $urandom % 12;
			if (kind[i] == PAIR && i < LEN - 2) begin
				kind[i] = BASE;
				base[i] = 1 + $urandom % 7;
				kind[i + 1] = JALR;
				i++;
			end else if (kind[i] == PAIR) begin
				kind[i] = 8;
			end
		end
		kind[LEN - 1] = HALT;
		for (int i = 0; i < LEN; i++) begin
			sel = $urandom;
			w.word = i_type($urandom, $urandom % 8, f3s[sel % 5], $urandom % 8, isa_pkg::OP_IMM);
			case (kind[i])
				LUI: w.word = {20'($urandom), 5'($urandom % 8), isa_pkg::OP_LUI};
				AUIPC: w.word = {20'($urandom), 5'($urandom % 8), isa_pkg::OP_AUIPC};
				BASE: w.word = {20'b0, base[i], isa_pkg::OP_AUIPC};
				JAL: w.word = jal_word((target_of(i) - i) * 4, $urandom % 8);
				JALR: w.word = i_type((target_of(i) - i + 1) * 4, base[i - 1],
					isa_pkg::F3_ADD, $urandom % 8, isa_pkg::OP_JALR);
				BEQ, BNE: w.word = b_type((target_of(i) - i) * 4, $urandom % 8, $urandom % 8,
					kind[i] == BNE ? isa_pkg::F3_BNE : isa_pkg::F3_BEQ);
				LW: w.word = i_type(4 * ($urandom % 64), 5'd0, isa_pkg::F3_WORD,
					$urandom % 8, isa_pkg::OP_LOAD);
				SW: begin
					w.word = i_type(4 * ($urandom % 64), 5'd0, isa_pkg::F3_WORD, 5'd0,
						isa_pkg::OP_STORE);
					w.s.imm_lo = w.s.rs2;	// low offset bits start out in rs2
					w.s.rs2 = $urandom % 8;
				end
				10, 11: begin	// register-register, sub on the sixth pick
					w.r.opcode = isa_pkg::OP_REG;
					w.r.rs2 = $urandom % 8;
					w.r.funct7 = (sel % 6 == 5) ? isa_pkg::F7_SUB : 7'b0;
					if (sel % 6 == 5)
						w.r.funct3 = isa_pkg::F3_ADD;
				end
				HALT: w.word = jal_word(21'd0, 5'd0);
				default: ;
			endcase
			imem[i] = w.word;
		end
	endtask

	initial begin
		int errors_before, retired_before, asserts_before, cycles;
		logic done;
		reset = 1'b0;
		void'($urandom(45459));
		for (int test = 0; test < TESTS; test++) begin
			asserts_before = six_stage_pipeline_inst.assertions_inst.failures;
			@(posedge clk);
			#2 reset = 1'b0;
			build_program();
			repeat (10) @(posedge clk);
			#2 reset = 1'b1;
			errors_before = checker_inst.errors;
			retired_before = checker_inst.retired;
			done = 1'b0;
			cycles = 0;
			while (!done && cycles < 2000) begin
				@(posedge clk);
				cycles++;
				done = retire_valid && retire_pc == HALT_PC;
			end
			#2;
			if (!done) begin
				$display("test %0d: halt not reached within 2000 cycles", test);
				failed++;
			end else if (checker_inst.errors != errors_before ||
					six_stage_pipeline_inst.assertions_inst.failures != asserts_before) begin
				failed++;
			end
			$display("test %0d: %0d retired in %0d cycles, %0d mismatches", test,
				checker_inst.retired - retired_before, cycles,
				checker_inst.errors - errors_before);
		end
		$display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures in total",
			TESTS, failed, checker_inst.errors,
			six_stage_pipeline_inst.assertions_inst.failures);
		if (failed == 0 && checker_inst.errors == 0 &&
				six_stage_pipeline_inst.assertions_inst.failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end
endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps
// operand select and alu with zero flag
module alu (
	input logic [isa_pkg::XLEN-1:0] rs1,
	input logic [isa_pkg::XLEN-1:0] rs2,
	input logic [isa_pkg::XLEN-1:0] immediate,
	input logic [isa_pkg::XLEN-1:0] pc,
	input logic [1:0] alu_src1,
	input logic alu_src2,
	input logic [2:0] alu_op,
	output logic [isa_pkg::XLEN-1:0] result,
	output logic zero
);
	logic [isa_pkg::XLEN-1:0] a, b;

	always_comb begin
		case (alu_src1)
			pipe_pkg::SRC1_PC: a = pc;	// auipc
			pipe_pkg::SRC1_ZERO: a = '0;
			default: a = rs1;
		endcase
		b = (alu_src2 == pipe_pkg::SRC2_IMM) ? immediate : rs2;
		case (alu_op)
			pipe_pkg::ALU_ADD: result = a + b;
			pipe_pkg::ALU_SUB: result = a - b;
			pipe_pkg::ALU_AND: result = a & b;
			pipe_pkg::ALU_OR: result = a | b;
			pipe_pkg::ALU_XOR: result = a ^ b;
			pipe_pkg::ALU_SLT: result = {{(isa_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			pipe_pkg::ALU_PASS_B: result = b;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);	// equality test for branches
endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/1ps
// static branch prediction in rf
// branch resolution and mispredict detection in dm
module branch_unit (
	input logic rf_valid,
	input logic [isa_pkg::XLEN-1:0] rf_pc,
	input logic [isa_pkg::XLEN-1:0] rf_rs1,
	input logic [isa_pkg::XLEN-1:0] rf_immediate,
	input logic rf_branch,
	input logic rf_jump,
	input logic rf_jalr,
	output logic predict_taken,
	output logic [isa_pkg::XLEN-1:0] predicted_pc,
	input logic dm_valid,
	input logic [isa_pkg::XLEN-1:0] dm_pc,
	input logic [isa_pkg::XLEN-1:0] dm_target,
	input logic [isa_pkg::XLEN-1:0] dm_predicted_pc,
	input logic dm_branch,
	input logic dm_branch_ne,
	input logic dm_jump,
	input logic dm_zero,
	output logic mispredict,
	output logic [isa_pkg::XLEN-1:0] resolved_pc
);
	logic [isa_pkg::XLEN-1:0] jalr_sum;
	logic [isa_pkg::XLEN-1:0] target;
	logic taken;

	assign jalr_sum = rf_rs1 + rf_immediate;	// rs1 already forwarded
	assign target = rf_jalr ? {jalr_sum[isa_pkg::XLEN-1:1], 1'b0} : rf_pc + rf_immediate;

	// backward taken, forward not taken
	assign predict_taken = rf_valid && (rf_jump || (rf_branch && rf_immediate[isa_pkg::XLEN-1]));
	assign predicted_pc = predict_taken ? target : rf_pc + 4;

	assign taken = dm_jump || (dm_branch && (dm_zero != dm_branch_ne));
	assign resolved_pc = taken ? dm_target : dm_pc + 4;
	assign mispredict = dm_valid && resolved_pc != dm_predicted_pc;
endmodule

// File: verilog/forward_if.sv
`timescale 1ns/1ps
// destination info of ex, dm and wb for operand forwarding
interface forward_if;
	logic [4:0] ex_rd_index;
	logic ex_write;
	logic ex_load;	// data not there until dm
	logic [isa_pkg::XLEN-1:0] ex_value;
	logic [4:0] dm_rd_index;
	logic dm_write;
	logic [isa_pkg::XLEN-1:0] dm_value;
	logic [4:0] wb_rd_index;
	logic wb_write;
	logic [isa_pkg::XLEN-1:0] wb_value;

	modport source(output ex_rd_index, ex_write, ex_load, ex_value,
		dm_rd_index, dm_write, dm_value, wb_rd_index, wb_write, wb_value);
	modport sink(input ex_rd_index, ex_write, ex_load, ex_value,
		dm_rd_index, dm_write, dm_value, wb_rd_index, wb_write, wb_value);
endinterface

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps
// operand forwarding into rf from ex, dm and wb
// load-use stall detection between rf and id
module hazard_unit (
	forward_if.sink fwd,
	input logic [4:0] rs1_index,
	input logic [4:0] rs2_index,
	input logic [isa_pkg::XLEN-1:0] rs1_file,
	input logic [isa_pkg::XLEN-1:0] rs2_file,
	input logic [4:0] id_rs1_index,
	input logic [4:0] id_rs2_index,
	input logic [4:0] rf_rd_index,
	input logic rf_load,
	output logic [isa_pkg::XLEN-1:0] rs1,
	output logic [isa_pkg::XLEN-1:0] rs2,
	output logic stall
);
	// youngest writer wins
	function automatic logic [isa_pkg::XLEN-1:0] pick(input logic [4:0] index,
			input logic [isa_pkg::XLEN-1:0] file_value);
		if (index == '0)
			return file_value;
		if (fwd.ex_write && !fwd.ex_load && fwd.ex_rd_index == index)
			return fwd.ex_value;
		if (fwd.dm_write && fwd.dm_rd_index == index)
			return fwd.dm_value;
		if (fwd.wb_write && fwd.wb_rd_index == index)
			return fwd.wb_value;
		return file_value;
	endfunction

	always_comb begin
		rs1 = pick(rs1_index, rs1_file);
		rs2 = pick(rs2_index, rs2_file);
	end

	assign stall = rf_load && rf_rd_index != '0 &&
		(rf_rd_index == id_rs1_index || rf_rd_index == id_rs2_index);
endmodule

// File: verilog/instruction_decode.sv
`timescale 1ns/1ps
// instruction decoder for the rv32i subset
// immediate per format plus control signals, unknown words become no-ops
module instruction_decode (
	input isa_pkg::instr_t instruction,
	output logic [isa_pkg::XLEN-1:0] immediate,
	output logic [4:0] rs1_index,
	output logic [4:0] rs2_index,
	output logic [4:0] rd_index,
	output logic rf_write,
	output logic mem_read,
	output logic mem_write,
	output logic [1:0] rd_select,
	output logic [2:0] alu_op,
	output logic [1:0] alu_src1,
	output logic alu_src2,
	output logic branch,
	output logic branch_ne,
	output logic jump,
	output logic jalr
);
	logic [isa_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [2:0] f3_op;	// funct3 mapping shared by op-imm and op
	logic f3_known;
	logic is_sub;

	assign imm_i = {{20{instruction.i.imm[11]}}, instruction.i.imm};
	assign imm_s = {{20{instruction.s.imm_hi[6]}}, instruction.s.imm_hi, instruction.s.imm_lo};
	assign imm_b = {{19{instruction.b.imm_12}}, instruction.b.imm_12, instruction.b.imm_11,
		instruction.b.imm_10_5, instruction.b.imm_4_1, 1'b0};
	assign imm_u = {instruction.u.imm, 12'b0};
	assign imm_j = {{11{instruction.j.imm_20}}, instruction.j.imm_20, instruction.j.imm_19_12,
		instruction.j.imm_11, instruction.j.imm_10_1, 1'b0};
	assign is_sub = instruction.r.funct7 == isa_pkg::F7_SUB && instruction.r.funct3 == isa_pkg::F3_ADD;

	always_comb begin
		f3_known = 1'b1;
		case (instruction.r.funct3)
			isa_pkg::F3_ADD: f3_op = pipe_pkg::ALU_ADD;
			isa_pkg::F3_SLT: f3_op = pipe_pkg::ALU_SLT;
			isa_pkg::F3_XOR: f3_op = pipe_pkg::ALU_XOR;
			isa_pkg::F3_OR: f3_op = pipe_pkg::ALU_OR;
			isa_pkg::F3_AND: f3_op = pipe_pkg::ALU_AND;
			default: begin	// shifts, sltu
				f3_op = pipe_pkg::ALU_PASS_B;
				f3_known = 1'b0;
			end
		endcase
	end

	always_comb begin
		immediate = imm_i;
		rs1_index = '0;
		rs2_index = '0;
		rd_index = instruction.r.rd;
		rf_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		rd_select = pipe_pkg::RD_ALU;
		alu_op = pipe_pkg::ALU_PASS_B;	// zero + imm, which is lui
		alu_src1 = pipe_pkg::SRC1_ZERO;
		alu_src2 = pipe_pkg::SRC2_IMM;
		branch = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		jalr = 1'b0;
		case (instruction.r.opcode)
			isa_pkg::OP_LUI: begin
				immediate = imm_u;
				rf_write = 1'b1;
			end
			isa_pkg::OP_AUIPC: begin
				immediate = imm_u;
				rf_write = 1'b1;
				alu_src1 = pipe_pkg::SRC1_PC;
				alu_op = pipe_pkg::ALU_ADD;
			end
			isa_pkg::OP_JAL: begin
				immediate = imm_j;
				rf_write = 1'b1;
				rd_select = pipe_pkg::RD_LINK;
				jump = 1'b1;
			end
			isa_pkg::OP_JALR: if (instruction.i.funct3 == isa_pkg::F3_ADD) begin
				rs1_index = instruction.i.rs1;
				rf_write = 1'b1;
				rd_select = pipe_pkg::RD_LINK;
				jump = 1'b1;
				jalr = 1'b1;
			end
			isa_pkg::OP_BRANCH: if (instruction.b.funct3 == isa_pkg::F3_BEQ ||
					instruction.b.funct3 == isa_pkg::F3_BNE) begin
				immediate = imm_b;
				rs1_index = instruction.b.rs1;
				rs2_index = instruction.b.rs2;
				alu_src1 = pipe_pkg::SRC1_RS1;
				alu_src2 = pipe_pkg::SRC2_RS2;
				alu_op = pipe_pkg::ALU_SUB;
				branch = 1'b1;
				branch_ne = instruction.b.funct3 == isa_pkg::F3_BNE;
			end
			isa_pkg::OP_LOAD: if (instruction.i.funct3 == isa_pkg::F3_WORD) begin
				rs1_index = instruction.i.rs1;
				rf_write = 1'b1;
				mem_read = 1'b1;
				rd_select = pipe_pkg::RD_MEM;
				alu_src1 = pipe_pkg::SRC1_RS1;
				alu_op = pipe_pkg::ALU_ADD;
			end
			isa_pkg::OP_STORE: if (instruction.s.funct3 == isa_pkg::F3_WORD) begin
				immediate = imm_s;
				rs1_index = instruction.s.rs1;
				rs2_index = instruction.s.rs2;
				mem_write = 1'b1;
				alu_src1 = pipe_pkg::SRC1_RS1;
				alu_op = pipe_pkg::ALU_ADD;
			end
			isa_pkg::OP_IMM: begin
				rs1_index = instruction.i.rs1;
				rf_write = f3_known;
				alu_src1 = pipe_pkg::SRC1_RS1;
				alu_op = f3_op;
			end
			isa_pkg::OP_REG: begin
				rs1_index = instruction.r.rs1;
				rs2_index = instruction.r.rs2;
				rf_write = f3_known && (instruction.r.funct7 == '0 || is_sub);
				alu_src1 = pipe_pkg::SRC1_RS1;
				alu_src2 = pipe_pkg::SRC2_RS2;
				alu_op = is_sub ? pipe_pkg::ALU_SUB : f3_op;
			end
			default: ;
		endcase
		if (rd_index == '0)
			rf_write = 1'b0;	// writes to x0 are dropped here
	end
endmodule

// File: verilog/isa_pkg.sv
// rv32i subset instruction-set definitions
// word width, memory address widths, opcodes and funct codes
// instruction word with its r, i, s, b, u and j views
package isa_pkg;
	localparam int XLEN = 32;
	localparam int IMEM_AW = 10;	// byte address bits
	localparam int DMEM_AW = 10;

	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;

	localparam logic [2:0] F3_ADD = 3'b000;	// also jalr
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_WORD = 3'b010;	// lw and sw
	localparam logic [6:0] F7_SUB = 7'b0100000;

	// one word, six field layouts
	typedef union packed {
		logic [31:0] word;
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic imm_11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0] rd;
			logic [6:0] opcode;
		} u;
		struct packed {
			logic imm_20;
			logic [9:0] imm_10_1;
			logic imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} instr_t;
endpackage

// File: verilog/pipe_pkg.sv
// micro-architecture encodings of the pipeline
// alu operations, operand sources, writeback select
package pipe_pkg;
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;	// branches compare with this
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR = 3'd3;
	localparam logic [2:0] ALU_XOR = 3'd4;
	localparam logic [2:0] ALU_SLT = 3'd5;
	localparam logic [2:0] ALU_PASS_B = 3'd6;

	// operand 1
	localparam logic [1:0] SRC1_RS1 = 2'd0;
	localparam logic [1:0] SRC1_PC = 2'd1;
	localparam logic [1:0] SRC1_ZERO = 2'd2;

	// operand 2
	localparam logic SRC2_RS2 = 1'b0;
	localparam logic SRC2_IMM = 1'b1;

	localparam logic [1:0] RD_ALU = 2'd0;
	localparam logic [1:0] RD_MEM = 2'd1;
	localparam logic [1:0] RD_LINK = 2'd2;	// pc + 4
endpackage

// File: verilog/register_file.sv
`timescale 1ns/1ps
// 31 general registers, x0 reads as zero
// two asynchronous reads, one write at the clock edge
module register_file (
	input logic clk,
	input logic reset,
	input logic [4:0] rs1_index,
	input logic [4:0] rs2_index,
	input logic [4:0] rd_index,
	input logic [isa_pkg::XLEN-1:0] rd,
	input logic write,
	output logic [isa_pkg::XLEN-1:0] rs1,
	output logic [isa_pkg::XLEN-1:0] rs2
);
	logic [isa_pkg::XLEN-1:0] regs [1:31];	// no storage for x0

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (write && rd_index != '0) begin
			regs[rd_index] <= rd;
		end
	end

	// no write-through, wb forwarding covers it
	assign rs1 = (rs1_index == '0) ? '0 : regs[rs1_index];
	assign rs2 = (rs2_index == '0) ? '0 : regs[rs2_index];
endmodule

// File: verilog/six_stage_pipeline.sv
`timescale 1ns/1ps
// six-stage in-order rv32i subset core: if, id, rf, ex, dm, wb
// pc, stage registers with valid bits, flush and stall control
// forwarding values, writeback mux and external memory ports
module six_stage_pipeline (
	input logic clk,
	input logic reset,
	output logic [isa_pkg::IMEM_AW-1:0] imem_addr,
	input logic [31:0] imem_data,
	output logic [isa_pkg::DMEM_AW-1:0] dmem_addr,
	output logic [isa_pkg::XLEN-1:0] dmem_wdata,
	output logic dmem_write,
	input logic [isa_pkg::XLEN-1:0] dmem_rdata,
	output logic retire_valid,
	output logic [isa_pkg::XLEN-1:0] retire_pc,
	output logic [4:0] retire_rd_index,
	output logic [isa_pkg::XLEN-1:0] retire_rd,
	output logic retire_write
);
	logic [isa_pkg::XLEN-1:0] pc, pc_next;
	logic stall, predict_taken, mispredict;
	logic [isa_pkg::XLEN-1:0] predicted_pc, resolved_pc;
	logic id_valid, rf_valid, ex_valid, dm_valid, wb_valid;

	logic [isa_pkg::XLEN-1:0] id_pc, id_immediate;
	logic [31:0] id_instruction;
	logic [4:0] id_rs1_index, id_rs2_index, id_rd_index;
	logic id_rf_write, id_mem_read, id_mem_write, id_alu_src2;
	logic id_branch, id_branch_ne, id_jump, id_jalr;
	logic [1:0] id_rd_select, id_alu_src1;
	logic [2:0] id_alu_op;

	logic [isa_pkg::XLEN-1:0] rf_pc, rf_immediate, rf_target;
	logic [isa_pkg::XLEN-1:0] rf_rs1_file, rf_rs2_file, rf_rs1, rf_rs2;
	logic [4:0] rf_rs1_index, rf_rs2_index, rf_rd_index;
	logic rf_rf_write, rf_mem_read, rf_mem_write, rf_alu_src2;
	logic rf_branch, rf_branch_ne, rf_jump, rf_jalr;
	logic [1:0] rf_rd_select, rf_alu_src1;
	logic [2:0] rf_alu_op;

	logic [isa_pkg::XLEN-1:0] ex_pc, ex_immediate, ex_rs1, ex_rs2, ex_result;
	logic [isa_pkg::XLEN-1:0] ex_target, ex_predicted_pc;
	logic [4:0] ex_rd_index;
	logic ex_rf_write, ex_mem_read, ex_mem_write, ex_alu_src2, ex_zero;
	logic ex_branch, ex_branch_ne, ex_jump;
	logic [1:0] ex_rd_select, ex_alu_src1;
	logic [2:0] ex_alu_op;

	logic [isa_pkg::XLEN-1:0] dm_pc, dm_result, dm_rs2, dm_target, dm_predicted_pc;
	logic [4:0] dm_rd_index;
	logic dm_rf_write, dm_mem_write, dm_zero, dm_branch, dm_branch_ne, dm_jump;
	logic [1:0] dm_rd_select;

	logic [isa_pkg::XLEN-1:0] wb_pc, wb_result, wb_rdata, wb_rd;
	logic [4:0] wb_rd_index;
	logic wb_rf_write;
	logic [1:0] wb_rd_select;

	forward_if fwd();

	function automatic logic [isa_pkg::XLEN-1:0] rd_value(input logic [1:0] select,
			input logic [isa_pkg::XLEN-1:0] result, mem, stage_pc);
		case (select)
			pipe_pkg::RD_MEM: return mem;
			pipe_pkg::RD_LINK: return stage_pc + 4;
			default: return result;
		endcase
	endfunction

	always_comb begin
		if (mispredict)
			pc_next = resolved_pc;	// dm outranks rf
		else if (predict_taken)
			pc_next = predicted_pc;
		else
			pc_next = pc + 4;
	end

	always_ff @(posedge clk) begin
		if (!reset)
			pc <= '0;
		else if (mispredict || !stall)
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			id_valid <= 1'b0;
			rf_valid <= 1'b0;
			ex_valid <= 1'b0;
			dm_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			if (mispredict || predict_taken)
				id_valid <= 1'b0;
			else if (!stall)
				id_valid <= 1'b1;
			rf_valid <= id_valid && !stall && !predict_taken && !mispredict;	// stall bubble
			ex_valid <= rf_valid && !mispredict;
			dm_valid <= ex_valid && !mispredict;
			wb_valid <= dm_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_pc <= pc;
			id_instruction <= imem_data;
		end
		rf_pc <= id_pc;
		rf_immediate <= id_immediate;
		rf_rs1_index <= id_rs1_index;
		rf_rs2_index <= id_rs2_index;
		rf_rd_index <= id_rd_index;
		rf_rf_write <= id_rf_write;
		rf_mem_read <= id_mem_read;
		rf_mem_write <= id_mem_write;
		rf_rd_select <= id_rd_select;
		rf_alu_op <= id_alu_op;
		rf_alu_src1 <= id_alu_src1;
		rf_alu_src2 <= id_alu_src2;
		rf_branch <= id_branch;
		rf_branch_ne <= id_branch_ne;
		rf_jump <= id_jump;
		rf_jalr <= id_jalr;
	end

	always_ff @(posedge clk) begin
		ex_pc <= rf_pc;
		ex_immediate <= rf_immediate;
		ex_rs1 <= rf_rs1;
		ex_rs2 <= rf_rs2;
		ex_rd_index <= rf_rd_index;
		ex_rf_write <= rf_rf_write;
		ex_mem_read <= rf_mem_read;
		ex_mem_write <= rf_mem_write;
		ex_rd_select <= rf_rd_select;
		ex_alu_op <= rf_alu_op;
		ex_alu_src1 <= rf_alu_src1;
		ex_alu_src2 <= rf_alu_src2;
		ex_branch <= rf_branch;
		ex_branch_ne <= rf_branch_ne;
		ex_jump <= rf_jump;
		ex_target <= rf_target;
		ex_predicted_pc <= predicted_pc;
		dm_pc <= ex_pc;
		dm_result <= ex_result;
		dm_zero <= ex_zero;
		dm_rs2 <= ex_rs2;
		dm_rd_index <= ex_rd_index;
		dm_rf_write <= ex_rf_write;
		dm_mem_write <= ex_mem_write;
		dm_rd_select <= ex_rd_select;
		dm_branch <= ex_branch;
		dm_branch_ne <= ex_branch_ne;
		dm_jump <= ex_jump;
		dm_target <= ex_target;
		dm_predicted_pc <= ex_predicted_pc;
		wb_pc <= dm_pc;
		wb_result <= dm_result;
		wb_rdata <= dmem_rdata;
		wb_rd_index <= dm_rd_index;
		wb_rf_write <= dm_rf_write;
		wb_rd_select <= dm_rd_select;
	end

	instruction_decode instruction_decode_inst (
		.instruction(id_instruction), .immediate(id_immediate),
		.rs1_index(id_rs1_index), .rs2_index(id_rs2_index), .rd_index(id_rd_index),
		.rf_write(id_rf_write), .mem_read(id_mem_read), .mem_write(id_mem_write),
		.rd_select(id_rd_select), .alu_op(id_alu_op),
		.alu_src1(id_alu_src1), .alu_src2(id_alu_src2),
		.branch(id_branch), .branch_ne(id_branch_ne), .jump(id_jump), .jalr(id_jalr));

	register_file register_file_inst (
		.clk(clk), .reset(reset),
		.rs1_index(rf_rs1_index), .rs2_index(rf_rs2_index),
		.rd_index(wb_rd_index), .rd(wb_rd), .write(wb_valid && wb_rf_write),
		.rs1(rf_rs1_file), .rs2(rf_rs2_file));

	// each stage offers the value it will write back
	assign fwd.ex_rd_index = ex_rd_index;
	assign fwd.ex_write = ex_valid && ex_rf_write;
	assign fwd.ex_load = ex_mem_read;
	assign fwd.ex_value = rd_value(ex_rd_select, ex_result, ex_result, ex_pc);
	assign fwd.dm_rd_index = dm_rd_index;
	assign fwd.dm_write = dm_valid && dm_rf_write;
	assign fwd.dm_value = rd_value(dm_rd_select, dm_result, dmem_rdata, dm_pc);
	assign fwd.wb_rd_index = wb_rd_index;
	assign fwd.wb_write = wb_valid && wb_rf_write;
	assign fwd.wb_value = wb_rd;

	hazard_unit hazard_unit_inst (
		.fwd(fwd.sink),
		.rs1_index(rf_rs1_index), .rs2_index(rf_rs2_index),
		.rs1_file(rf_rs1_file), .rs2_file(rf_rs2_file),
		.id_rs1_index(id_rs1_index), .id_rs2_index(id_rs2_index),
		.rf_rd_index(rf_rd_index), .rf_load(rf_valid && rf_mem_read),
		.rs1(rf_rs1), .rs2(rf_rs2), .stall(stall));

	branch_unit branch_unit_inst (
		.rf_valid(rf_valid), .rf_pc(rf_pc), .rf_rs1(rf_rs1), .rf_immediate(rf_immediate),
		.rf_branch(rf_branch), .rf_jump(rf_jump), .rf_jalr(rf_jalr),
		.predict_taken(predict_taken), .predicted_pc(predicted_pc),
		.dm_valid(dm_valid), .dm_pc(dm_pc), .dm_target(dm_target),
		.dm_predicted_pc(dm_predicted_pc), .dm_branch(dm_branch),
		.dm_branch_ne(dm_branch_ne), .dm_jump(dm_jump), .dm_zero(dm_zero),
		.mispredict(mispredict), .resolved_pc(resolved_pc));

	// taken target travels to dm, exact for jumps once predicted
	assign rf_target = predict_taken ? predicted_pc : rf_pc + rf_immediate;

	alu alu_inst (
		.rs1(ex_rs1), .rs2(ex_rs2), .immediate(ex_immediate), .pc(ex_pc),
		.alu_src1(ex_alu_src1), .alu_src2(ex_alu_src2), .alu_op(ex_alu_op),
		.result(ex_result), .zero(ex_zero));

	assign imem_addr = pc[isa_pkg::IMEM_AW-1:0];
	assign dmem_addr = dm_result[isa_pkg::DMEM_AW-1:0];
	assign dmem_wdata = dm_rs2;
	assign dmem_write = dm_valid && dm_mem_write;

	assign wb_rd = rd_value(wb_rd_select, wb_result, wb_rdata, wb_pc);
	assign retire_valid = wb_valid;
	assign retire_pc = wb_pc;
	assign retire_rd_index = wb_rd_index;
	assign retire_rd = wb_rd;
	assign retire_write = wb_valid && wb_rf_write;
endmodule
